// File: zr_ctrl_pkg.sv
// controller package: state, event and pc select enums, cause and width constants
package zr_ctrl_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // interrupt id coming from the interrupt controller
  localparam int unsigned IRQ_ID_W = 5;
  // cause field, one bit wider than the id so the irq flag fits on top
  localparam int unsigned CAUSE_W  = 6;

  ////////////////////////////////////////
  // exception causes
  ////////////////////////////////////////

  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_BREAKPOINT   = 6'd3;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE  = 6'd11;

  ////////////////////////////////////////
  // controller fsm
  ////////////////////////////////////////

  // main control states, all eight codes in use
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // one prioritized event per cycle from the id stage
  typedef enum logic [2:0] {
    EV_NONE,
    EV_BRANCH,
    EV_JUMP,
    EV_FLUSH,
    EV_IRQ
  } ctrl_event_e;

  ////////////////////////////////////////
  // fetch stage selects
  ////////////////////////////////////////

  // encodings shared with the fetch stage pc mux
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_sel_e;

  // exception vector offset select
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'd0,
    EXC_PC_ECALL   = 2'd1,
    EXC_PC_IRQ     = 2'd3
  } exc_pc_sel_e;

endpackage

// File: zr_insn_classify.sv
// id stage classifier: reduces decoder and interrupt inputs to one decode event
module zr_insn_classify (
  input  zr_ctrl_pkg::ctrl_state_e state_i,
  // decoder view of the instruction in id
  input  logic                     instr_valid_i,
  input  logic                     branch_set_i,
  input  logic                     jump_set_i,
  input  logic                     ecall_insn_i,
  input  logic                     illegal_insn_i,
  input  logic                     mret_insn_i,
  input  logic                     ebrk_insn_i,
  input  logic                     csr_status_i,
  input  logic                     pipe_flush_i,
  // interrupt blocking conditions
  input  logic                     instr_multicycle_i,
  input  logic                     branch_in_id_i,
  input  logic                     irq_req_ctrl_i,
  input  logic                     m_ie_i,
  output zr_ctrl_pkg::ctrl_event_e ev_o,
  output logic                     exc_kill_o
);
  import zr_ctrl_pkg::*;

  // any instruction that has to drain the pipe
  logic special;
  // request seen at an interruptible point, enable not yet applied
  logic irq_window;
  // request seen with the enable applied
  logic irq_enabled;

  assign special = ecall_insn_i | illegal_insn_i | mret_insn_i |
                   ebrk_insn_i  | csr_status_i   | pipe_flush_i;

  assign irq_window  = irq_req_ctrl_i & ~instr_multicycle_i & ~branch_in_id_i;
  assign irq_enabled = irq_req_ctrl_i & m_ie_i;

  always_comb
  begin
    ev_o       = EV_NONE;
    exc_kill_o = 1'b0;

    unique case (state_i)
      // pipe is empty here, only the enable matters
      FIRST_FETCH:
      begin
        if (irq_enabled)
          ev_o = EV_IRQ;
      end

      DECODE:
      begin
        if (!instr_valid_i)
        begin
          // bubble in id, nothing can block the interrupt
          if (irq_enabled)
            ev_o = EV_IRQ;
        end
        else if (branch_set_i && !jump_set_i && !special)
          ev_o = EV_BRANCH;
        else if (jump_set_i && !branch_set_i && !special)
          ev_o = EV_JUMP;
        else if (special && !branch_set_i && !jump_set_i)
          ev_o = EV_FLUSH;
        else if (irq_window && m_ie_i)
          ev_o = EV_IRQ;
        else
          exc_kill_o = irq_window;  // pending but masked
      end

      default:
      begin
        ev_o = EV_NONE;
      end
    endcase
  end

endmodule

// File: zr_pc_ctrl.sv
// pc redirect and trap side outputs: pc selects, causes, csr strobes, acks, perf pulses
module zr_pc_ctrl (
  input  zr_ctrl_pkg::ctrl_state_e            state_i,
  input  zr_ctrl_pkg::ctrl_event_e            ev_i,
  // flushing instruction kind, sampled while in FLUSH
  input  logic                                ecall_insn_i,
  input  logic                                illegal_insn_i,
  input  logic                                mret_insn_i,
  input  logic                                ebrk_insn_i,
  input  logic                                pipe_flush_i,
  input  logic [zr_ctrl_pkg::IRQ_ID_W-1:0]    irq_id_ctrl_i,
  // to prefetcher
  output logic                                pc_set_o,
  output zr_ctrl_pkg::pc_sel_e                pc_mux_o,
  output zr_ctrl_pkg::exc_pc_sel_e            exc_pc_mux_o,
  // to csr file
  output logic [zr_ctrl_pkg::CAUSE_W-1:0]     exc_cause_o,
  output logic [zr_ctrl_pkg::CAUSE_W-1:0]     csr_cause_o,
  output logic                                csr_save_if_o,
  output logic                                csr_save_id_o,
  output logic                                csr_save_cause_o,
  output logic                                csr_restore_mret_id_o,
  // interrupt controller handshake
  output logic                                irq_ack_o,
  output logic [zr_ctrl_pkg::IRQ_ID_W-1:0]    irq_id_o,
  output logic                                exc_ack_o,
  // performance counters
  output logic                                perf_jump_o,
  output logic                                perf_tbranch_o,
  // to fsm
  output logic                                flush_sleep_o
);
  import zr_ctrl_pkg::*;

  // id passes straight through, only the ack qualifies it
  assign irq_id_o = irq_id_ctrl_i;

  always_comb
  begin
    pc_set_o              = 1'b0;
    pc_mux_o              = PC_BOOT;
    exc_pc_mux_o          = EXC_PC_IRQ;
    exc_cause_o           = '0;
    csr_cause_o           = '0;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_save_cause_o      = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    irq_ack_o             = 1'b0;
    exc_ack_o             = 1'b0;
    perf_jump_o           = 1'b0;
    perf_tbranch_o        = 1'b0;
    flush_sleep_o         = 1'b0;

    unique case (state_i)
      ////////////////////////////////////////
      // boot
      ////////////////////////////////////////
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
      end

      ////////////////////////////////////////
      // decode time control flow
      ////////////////////////////////////////
      DECODE:
      begin
        // redirect in the same cycle, no extra state
        if (ev_i == EV_BRANCH)
        begin
          pc_set_o       = 1'b1;
          pc_mux_o       = PC_JUMP;
          perf_tbranch_o = 1'b1;
        end
        else if (ev_i == EV_JUMP)
        begin
          pc_set_o    = 1'b1;
          pc_mux_o    = PC_JUMP;
          perf_jump_o = 1'b1;
        end
      end

      ////////////////////////////////////////
      // flush
      ////////////////////////////////////////
      FLUSH:
      begin
        // ecall first, then illegal, mret, ebreak, then the rest
        if (ecall_insn_i)
        begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_ECALL;
          exc_cause_o      = EXC_CAUSE_ECALL_MMODE;
          csr_cause_o      = EXC_CAUSE_ECALL_MMODE;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end
        else if (illegal_insn_i)
        begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_ILLINSN;
          exc_cause_o      = EXC_CAUSE_ILLEGAL_INSN;
          csr_cause_o      = EXC_CAUSE_ILLEGAL_INSN;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end
        else if (mret_insn_i)
        begin
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_ERET;
          csr_restore_mret_id_o = 1'b1;
        end
        else if (ebrk_insn_i)
          // cause only, no redirect without the debug unit
          exc_cause_o = EXC_CAUSE_BREAKPOINT;
        else
          // csr status needs nothing, wfi style flush ends in sleep
          flush_sleep_o = pipe_flush_i;
      end

      ////////////////////////////////////////
      // interrupt entry
      ////////////////////////////////////////
      IRQ_TAKEN:
      begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_IRQ;
        // top bit tells the csr file this is an interrupt
        exc_cause_o      = {1'b0, irq_id_ctrl_i};
        csr_cause_o      = {1'b1, irq_id_ctrl_i};
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
      end

      default:
      begin
        pc_set_o = 1'b0;
      end
    endcase
  end

endmodule

// File: zr_ctrl_fsm.sv
// main control fsm: state register, next state, busy, request, halts and write enable gating
module zr_ctrl_fsm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_enable_i,
  input  zr_ctrl_pkg::ctrl_event_e ev_i,
  input  logic                     flush_sleep_i,
  input  logic                     id_ready_i,
  // raw external line, wakes from sleep even when masked
  input  logic                     irq_i,
  input  logic                     instr_valid_i,
  input  logic                     illegal_insn_i,
  output zr_ctrl_pkg::ctrl_state_e state_o,
  output logic                     ctrl_busy_o,
  output logic                     instr_req_o,
  output logic                     first_fetch_o,
  output logic                     is_decoding_o,
  output logic                     deassert_we_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o
);
  import zr_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  assign state_o = state_q;

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb
  begin
    state_d       = state_q;
    ctrl_busy_o   = 1'b1;
    instr_req_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    unique case (state_q)
      // hold off fetching until enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // boot pc goes out this cycle
      BOOT_SET:
      begin
        state_d = FIRST_FETCH;
      end

      // one cycle to let the flush settle
      WAIT_SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (irq_i)
          state_d = FIRST_FETCH;
      end

      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        // stall on the if miss until id accepts
        if (id_ready_i)
          state_d = DECODE;
        // an enabled interrupt wins over leaving for decode
        if (ev_i == EV_IRQ)
        begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      DECODE:
      begin
        is_decoding_o = instr_valid_i;
        // branch and jump stay in decode, pc side handles them
        if (ev_i == EV_FLUSH)
        begin
          state_d   = FLUSH;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
        else if (ev_i == EV_IRQ)
        begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // insert a bubble while the trap side acts
      FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_d   = flush_sleep_i ? WAIT_SLEEP : DECODE;
      end

      IRQ_TAKEN:
      begin
        state_d = DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // write enable gating
  ////////////////////////////////////////

  // next instruction must not write back unless it is really decoded and legal
  assign deassert_we_o = ~is_decoding_o | illegal_insn_i;

  // state register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= RESET;
    else
      state_q <= state_d;
  end

endmodule

// File: zr_controller.sv
// controller top: classifier, pc and trap control, main fsm
module zr_controller (
  input  logic                             clk,
  input  logic                             rst_n,
  // core control
  input  logic                             fetch_enable_i,
  output logic                             ctrl_busy_o,
  output logic                             first_fetch_o,
  output logic                             is_decoding_o,
  output logic                             deassert_we_o,
  // decoder
  input  logic                             illegal_insn_i,
  input  logic                             ecall_insn_i,
  input  logic                             mret_insn_i,
  input  logic                             pipe_flush_i,
  input  logic                             ebrk_insn_i,
  input  logic                             csr_status_i,
  input  logic                             instr_valid_i,
  // prefetcher
  output logic                             instr_req_o,
  output logic                             pc_set_o,
  output zr_ctrl_pkg::pc_sel_e             pc_mux_o,
  output zr_ctrl_pkg::exc_pc_sel_e         exc_pc_mux_o,
  // branch and jump
  input  logic                             branch_in_id_i,
  input  logic                             branch_set_i,
  input  logic                             jump_set_i,
  input  logic                             instr_multicycle_i,
  // interrupts
  input  logic                             irq_i,
  input  logic                             irq_req_ctrl_i,
  input  logic [zr_ctrl_pkg::IRQ_ID_W-1:0] irq_id_ctrl_i,
  input  logic                             m_ie_i,
  output logic                             irq_ack_o,
  output logic [zr_ctrl_pkg::IRQ_ID_W-1:0] irq_id_o,
  // exceptions and csr
  output logic [zr_ctrl_pkg::CAUSE_W-1:0]  exc_cause_o,
  output logic                             exc_ack_o,
  output logic                             exc_kill_o,
  output logic                             csr_save_if_o,
  output logic                             csr_save_id_o,
  output logic [zr_ctrl_pkg::CAUSE_W-1:0]  csr_cause_o,
  output logic                             csr_restore_mret_id_o,
  output logic                             csr_save_cause_o,
  // stalls
  output logic                             halt_if_o,
  output logic                             halt_id_o,
  input  logic                             id_ready_i,
  // performance counters
  output logic                             perf_jump_o,
  output logic                             perf_tbranch_o
);
  import zr_ctrl_pkg::*;

  // fsm state seen by both combinational units
  ctrl_state_e state;
  // decode event from the classifier
  ctrl_event_e ev;
  // flush ends in sleep
  logic        flush_sleep;

  ////////////////////////////////////////
  // id stage classification
  ////////////////////////////////////////

  zr_insn_classify i_classify (
    .state_i            (state),
    .instr_valid_i      (instr_valid_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .ecall_insn_i       (ecall_insn_i),
    .illegal_insn_i     (illegal_insn_i),
    .mret_insn_i        (mret_insn_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .csr_status_i       (csr_status_i),
    .pipe_flush_i       (pipe_flush_i),
    .instr_multicycle_i (instr_multicycle_i),
    .branch_in_id_i     (branch_in_id_i),
    .irq_req_ctrl_i     (irq_req_ctrl_i),
    .m_ie_i             (m_ie_i),
    .ev_o               (ev),
    .exc_kill_o         (exc_kill_o)
  );

  ////////////////////////////////////////
  // pc and trap side
  ////////////////////////////////////////

  zr_pc_ctrl i_pc_ctrl (
    .state_i               (state),
    .ev_i                  (ev),
    .ecall_insn_i          (ecall_insn_i),
    .illegal_insn_i        (illegal_insn_i),
    .mret_insn_i           (mret_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .pipe_flush_i          (pipe_flush_i),
    .irq_id_ctrl_i         (irq_id_ctrl_i),
    .pc_set_o              (pc_set_o),
    .pc_mux_o              (pc_mux_o),
    .exc_pc_mux_o          (exc_pc_mux_o),
    .exc_cause_o           (exc_cause_o),
    .csr_cause_o           (csr_cause_o),
    .csr_save_if_o         (csr_save_if_o),
    .csr_save_id_o         (csr_save_id_o),
    .csr_save_cause_o      (csr_save_cause_o),
    .csr_restore_mret_id_o (csr_restore_mret_id_o),
    .irq_ack_o             (irq_ack_o),
    .irq_id_o              (irq_id_o),
    .exc_ack_o             (exc_ack_o),
    .perf_jump_o           (perf_jump_o),
    .perf_tbranch_o        (perf_tbranch_o),
    .flush_sleep_o         (flush_sleep)
  );

  ////////////////////////////////////////
  // main fsm
  ////////////////////////////////////////

  zr_ctrl_fsm i_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .ev_i           (ev),
    .flush_sleep_i  (flush_sleep),
    .id_ready_i     (id_ready_i),
    .irq_i          (irq_i),
    .instr_valid_i  (instr_valid_i),
    .illegal_insn_i (illegal_insn_i),
    .state_o        (state),
    .ctrl_busy_o    (ctrl_busy_o),
    .instr_req_o    (instr_req_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .deassert_we_o  (deassert_we_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o)
  );

endmodule

// File: tb_clk_gen.sv
// testbench clock and reset generator
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // period of 10
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset low for two cycles, released away from the rising edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tb_controller_properties.sv
// bound checker: concurrent assertions on boot, control flow, traps, interrupts and sleep
module tb_controller_properties (
  input  logic                             clk,
  input  logic                             rst_n,
  input  zr_ctrl_pkg::ctrl_state_e         state_i,
  input  logic                             fetch_enable_i, id_ready_i, irq_i,
  input  logic                             instr_valid_i, branch_set_i, jump_set_i,
  input  logic                             illegal_insn_i, ecall_insn_i, mret_insn_i,
  input  logic                             ebrk_insn_i, csr_status_i, pipe_flush_i,
  input  logic                             instr_multicycle_i, branch_in_id_i,
  input  logic                             irq_req_ctrl_i, m_ie_i,
  input  logic [zr_ctrl_pkg::IRQ_ID_W-1:0] irq_id_ctrl_i,
  input  logic                             instr_req_o, pc_set_o,
  input  zr_ctrl_pkg::pc_sel_e             pc_mux_o,
  input  zr_ctrl_pkg::exc_pc_sel_e         exc_pc_mux_o,
  input  logic [zr_ctrl_pkg::CAUSE_W-1:0]  exc_cause_o, csr_cause_o,
  input  logic                             csr_save_if_o, csr_save_id_o, csr_save_cause_o,
  input  logic                             csr_restore_mret_id_o,
  input  logic                             irq_ack_o, exc_ack_o, exc_kill_o,
  input  logic [zr_ctrl_pkg::IRQ_ID_W-1:0] irq_id_o,
  input  logic                             first_fetch_o, is_decoding_o, deassert_we_o,
  input  logic                             ctrl_busy_o,
  input  logic                             halt_if_o, halt_id_o, perf_jump_o, perf_tbranch_o
);
  import zr_ctrl_pkg::*;

  // first failing check, read by the testbench top
  bit          fail_seen = 1'b0;
  string       fail_name;
  logic [31:0] fail_got;
  logic [31:0] fail_exp;
  time         fail_time;

  // instruction that drains the pipe
  logic        special;
  // decode cycle with a valid instruction
  logic        in_decode;
  logic [5:0]  jmp_vec;
  logic [3:0]  sleep_vec;
  logic [13:0] exc_vec;
  logic [13:0] ill_exp;
  logic [13:0] ecall_exp;
  logic [26:0] irq_vec;
  logic [26:0] irq_exp;

  assign special   = ecall_insn_i | illegal_insn_i | mret_insn_i |
                     ebrk_insn_i | csr_status_i | pipe_flush_i;
  assign in_decode = (state_i == DECODE) && instr_valid_i;

  // {pc_set, pc_mux, tbranch, jump}
  assign jmp_vec   = {pc_set_o, pc_mux_o, perf_tbranch_o, perf_jump_o};
  // busy and request low, both halts high while asleep
  assign sleep_vec = {ctrl_busy_o, instr_req_o, halt_if_o, halt_id_o};
  assign exc_vec   = {pc_set_o, pc_mux_o, exc_pc_mux_o, exc_cause_o,
                      csr_save_id_o, csr_save_cause_o};
  assign ill_exp   = {1'b1, PC_EXCEPTION, EXC_PC_ILLINSN, EXC_CAUSE_ILLEGAL_INSN, 2'b11};
  assign ecall_exp = {1'b1, PC_EXCEPTION, EXC_PC_ECALL, EXC_CAUSE_ECALL_MMODE, 2'b11};
  assign irq_vec   = {pc_set_o, pc_mux_o, exc_pc_mux_o, irq_ack_o, exc_ack_o, irq_id_o,
                      exc_cause_o, csr_cause_o, csr_save_if_o, csr_save_cause_o};
  // cause carries the irq flag in its top bit only on the csr side
  assign irq_exp   = {1'b1, PC_EXCEPTION, EXC_PC_IRQ, 2'b11, irq_id_ctrl_i,
                      1'b0, irq_id_ctrl_i, 1'b1, irq_id_ctrl_i, 2'b11};

  task automatic record_failure(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $error("%s check failed", name);
    if (!fail_seen)
    begin
      fail_seen = 1'b1;
      fail_name = name;
      fail_got  = got;
      fail_exp  = exp;
      fail_time = $time;
    end
  endtask

  ////////////////////////////////////////
  // boot
  ////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == RESET) |-> {instr_req_o, pc_set_o} == 2'b00)
    else record_failure("instr_req_o,pc_set_o", $sampled({instr_req_o, pc_set_o}), 0);

  a_boot: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == RESET && fetch_enable_i) |=> {pc_set_o, pc_mux_o} == {1'b1, PC_BOOT})
    else record_failure("pc_set_o,pc_mux_o", $sampled({pc_set_o, pc_mux_o}), {1'b1, PC_BOOT});

  // boot redirect is a single pulse
  a_boot_once: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == BOOT_SET) |=> !pc_set_o)
    else record_failure("pc_set_o", $sampled(pc_set_o), 0);

  a_ff_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (first_fetch_o && !id_ready_i && !(irq_req_ctrl_i && m_ie_i)) |=> first_fetch_o)
    else record_failure("first_fetch_o", $sampled(first_fetch_o), 1);

  ////////////////////////////////////////
  // decode time control flow
  ////////////////////////////////////////

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && branch_set_i && !jump_set_i && !special)
    |-> jmp_vec == {1'b1, PC_JUMP, 2'b10})
    else record_failure("pc_set_o,pc_mux_o,perf", $sampled(jmp_vec), {1'b1, PC_JUMP, 2'b10});

  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && jump_set_i && !branch_set_i && !special)
    |-> jmp_vec == {1'b1, PC_JUMP, 2'b01})
    else record_failure("pc_set_o,pc_mux_o,perf", $sampled(jmp_vec), {1'b1, PC_JUMP, 2'b01});

  ////////////////////////////////////////
  // write enable gating
  ////////////////////////////////////////

  // a legal instruction in decode may write back
  a_decoding: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && !illegal_insn_i) |-> {is_decoding_o, deassert_we_o} == 2'b10)
    else record_failure("is_decoding_o,deassert_we_o",
                        $sampled({is_decoding_o, deassert_we_o}), 2'b10);

  // outside decode nothing is decoded and write back stays blocked
  a_not_decoding: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i != DECODE) |-> {is_decoding_o, deassert_we_o} == 2'b01)
    else record_failure("is_decoding_o,deassert_we_o",
                        $sampled({is_decoding_o, deassert_we_o}), 2'b01);

  ////////////////////////////////////////
  // exceptions and mret
  ////////////////////////////////////////

  a_illegal_we: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == DECODE && illegal_insn_i) |-> deassert_we_o)
    else record_failure("deassert_we_o", $sampled(deassert_we_o), 1);

  a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && illegal_insn_i && !ecall_insn_i && !branch_set_i && !jump_set_i)
    |=> exc_vec == ill_exp)
    else record_failure("illegal trap outputs", $sampled(exc_vec), $sampled(ill_exp));

  a_ecall: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && ecall_insn_i && !branch_set_i && !jump_set_i) |=> exc_vec == ecall_exp)
    else record_failure("ecall trap outputs", $sampled(exc_vec), $sampled(ecall_exp));

  a_mret: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && mret_insn_i && !ecall_insn_i && !illegal_insn_i &&
     !branch_set_i && !jump_set_i)
    |=> {pc_set_o, pc_mux_o, csr_restore_mret_id_o} == {1'b1, PC_ERET, 1'b1})
    else record_failure("pc_set_o,pc_mux_o,csr_restore_mret_id_o",
                        $sampled({pc_set_o, pc_mux_o, csr_restore_mret_id_o}),
                        {1'b1, PC_ERET, 1'b1});

  ////////////////////////////////////////
  // interrupts and sleep
  ////////////////////////////////////////

  a_irq: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == DECODE && !instr_valid_i && irq_req_ctrl_i && m_ie_i) |=> irq_vec == irq_exp)
    else record_failure("irq entry outputs", $sampled(irq_vec), $sampled(irq_exp));

  // masked request in an interruptible slot
  a_irq_kill: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && irq_req_ctrl_i && !m_ie_i && !instr_multicycle_i && !branch_in_id_i &&
     !special && !branch_set_i && !jump_set_i) |-> exc_kill_o)
    else record_failure("exc_kill_o", $sampled(exc_kill_o), 1);

  a_irq_no_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == DECODE && irq_req_ctrl_i && !m_ie_i) |=> !irq_ack_o)
    else record_failure("irq_ack_o", $sampled(irq_ack_o), 0);

  a_sleep_enter: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == FLUSH && pipe_flush_i && !ecall_insn_i && !illegal_insn_i &&
     !mret_insn_i && !ebrk_insn_i) |-> ##2 sleep_vec == 4'b0011)
    else record_failure("ctrl_busy_o,instr_req_o,halts", $sampled(sleep_vec), 4'b0011);

  a_sleep_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == SLEEP && !irq_i) |=> sleep_vec == 4'b0011)
    else record_failure("ctrl_busy_o,instr_req_o,halts", $sampled(sleep_vec), 4'b0011);

  a_wake: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == SLEEP && irq_i) |=> first_fetch_o)
    else record_failure("first_fetch_o", $sampled(first_fetch_o), 1);

endmodule

// File: tb_controller.sv
// testbench top: clock, dut, bound checker, directed stimulus, timeout and result
module tb_controller;
  import zr_ctrl_pkg::*;

  logic clk;
  logic rst_n;

  // core control and decoder
  logic fetch_enable_i, ctrl_busy_o, first_fetch_o, is_decoding_o, deassert_we_o;
  logic illegal_insn_i, ecall_insn_i, mret_insn_i, pipe_flush_i, ebrk_insn_i;
  logic csr_status_i, instr_valid_i;
  // prefetcher
  logic        instr_req_o, pc_set_o;
  pc_sel_e     pc_mux_o;
  exc_pc_sel_e exc_pc_mux_o;
  // branch and jump
  logic branch_in_id_i, branch_set_i, jump_set_i, instr_multicycle_i;
  // interrupts
  logic                irq_i, irq_req_ctrl_i, m_ie_i, irq_ack_o;
  logic [IRQ_ID_W-1:0] irq_id_ctrl_i, irq_id_o;
  // exceptions and csr
  logic [CAUSE_W-1:0] exc_cause_o, csr_cause_o;
  logic exc_ack_o, exc_kill_o, csr_save_if_o, csr_save_id_o;
  logic csr_restore_mret_id_o, csr_save_cause_o;
  // stalls and perf counters
  logic halt_if_o, halt_id_o, id_ready_i, perf_jump_o, perf_tbranch_o;

  // galois lfsr state and last drawn value
  logic [31:0] lfsr = 32'h6491;
  logic [31:0] rnd;
  int unsigned cycle_cnt = 0;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  zr_controller i_dut (.*);

  bind zr_controller tb_controller_properties i_props (.state_i(state), .*);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic clear_insn;
    instr_valid_i  = 1'b0;
    branch_set_i   = 1'b0;
    jump_set_i     = 1'b0;
    illegal_insn_i = 1'b0;
    ecall_insn_i   = 1'b0;
    mret_insn_i    = 1'b0;
    ebrk_insn_i    = 1'b0;
    csr_status_i   = 1'b0;
    pipe_flush_i   = 1'b0;
  endtask

  // id is halted, so the flushing instruction stays visible through FLUSH
  task automatic hold_through_flush;
    instr_valid_i = 1'b1;
    repeat (2) @(negedge clk);
    clear_insn();
  endtask

  task automatic take_irq;
    draw_bits(IRQ_ID_W, rnd);
    irq_id_ctrl_i  = rnd[IRQ_ID_W-1:0];
    m_ie_i         = 1'b1;
    irq_req_ctrl_i = 1'b1;
    @(negedge clk);
    while (!irq_ack_o)
      @(negedge clk);
    irq_req_ctrl_i = 1'b0;
    @(negedge clk);
  endtask

  task automatic report_failure;
    $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", i_dut.i_props.fail_time,
             i_dut.i_props.fail_name, i_dut.i_props.fail_got, i_dut.i_props.fail_exp);
    $display("Regression failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  ////////////////////////////////////////
  // monitors
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    if (i_dut.i_props.fail_seen)
      report_failure();
  end

  // directed run is well under this limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == 400)
    begin
      $display("timeout: run did not finish within 400 cycles");
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin
    fetch_enable_i     = 1'b0;
    id_ready_i         = 1'b0;
    irq_i              = 1'b0;
    irq_req_ctrl_i     = 1'b0;
    irq_id_ctrl_i      = '0;
    m_ie_i             = 1'b0;
    branch_in_id_i     = 1'b0;
    instr_multicycle_i = 1'b0;
    rnd                = '0;
    clear_insn();

    // boot, idle in reset first
    @(posedge rst_n);
    repeat (3) @(negedge clk);
    fetch_enable_i = 1'b1;
    @(negedge clk);
    while (!first_fetch_o)
      @(negedge clk);
    // random id stall of 0 to 7 cycles
    draw_bits(3, rnd);
    repeat (rnd) @(negedge clk);
    id_ready_i = 1'b1;
    while (first_fetch_o)
      @(negedge clk);

    // taken branch, then jump
    instr_valid_i = 1'b1;
    branch_set_i  = 1'b1;
    @(negedge clk);
    branch_set_i = 1'b0;
    jump_set_i   = 1'b1;
    @(negedge clk);
    clear_insn();

    // traps
    illegal_insn_i = 1'b1;
    hold_through_flush();
    ecall_insn_i = 1'b1;
    hold_through_flush();
    mret_insn_i = 1'b1;
    hold_through_flush();

    // enabled interrupts with random ids
    take_irq();
    take_irq();

    // masked request in an interruptible slot
    m_ie_i         = 1'b0;
    instr_valid_i  = 1'b1;
    irq_req_ctrl_i = 1'b1;
    @(negedge clk);
    irq_req_ctrl_i = 1'b0;
    instr_valid_i  = 1'b0;
    @(negedge clk);

    // wfi style flush into sleep, wake on irq line
    instr_valid_i = 1'b1;
    pipe_flush_i  = 1'b1;
    @(negedge clk);
    while (ctrl_busy_o)
      @(negedge clk);
    clear_insn();
    draw_bits(2, rnd);
    repeat (rnd + 2) @(negedge clk);
    irq_i = 1'b1;
    @(negedge clk);
    while (!first_fetch_o)
      @(negedge clk);
    irq_i = 1'b0;
    while (first_fetch_o)
      @(negedge clk);
    repeat (3) @(negedge clk);

    if (i_dut.i_props.fail_seen)
      report_failure();
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: filelist.f
zr_ctrl_pkg.sv
zr_insn_classify.sv
zr_pc_ctrl.sv
zr_ctrl_fsm.sv
zr_controller.sv
tb_clk_gen.sv
tb_controller_properties.sv
tb_controller.sv

// File: Bender.yml
package:
  name: zr_controller

sources:
  - zr_ctrl_pkg.sv
  - zr_insn_classify.sv
  - zr_pc_ctrl.sv
  - zr_ctrl_fsm.sv
  - zr_controller.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_controller_properties.sv
      - tb_controller.sv
